// ==== hdl/frontend_settings.svh ====
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// First fetch address after reset
`define FE_RESET_PC 32'h0000_1000

// Queue capacity in pairs, and the pointer width that indexes it
`define FE_QUEUE_PAIRS 4
`define FE_QUEUE_PTR_W 2

// Pair credits count 0 to FE_QUEUE_PAIRS, with headroom for the overflow check
`define FE_PAIR_CREDIT_W 3

// Backend credits held by the front end
`define FE_ISSUE_CREDIT_MAX 15
`define FE_ISSUE_CREDIT_W 5

`endif

// ==== hdl/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    // Operation class of a decoded instruction
    typedef enum logic [3:0] {
        OP_ALU     = 4'd0,
        OP_ALU_IMM = 4'd1,
        OP_LOAD    = 4'd2,
        OP_STORE   = 4'd3,
        OP_BRANCH  = 4'd4,
        OP_JUMP    = 4'd5,
        OP_UPPER   = 4'd6,
        OP_SYSTEM  = 4'd7
    } op_class_e;

    // One decoded instruction as it travels through the queue
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        op_class_e   op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        // Sign extended, already shifted for B, U and J formats
        logic [31:0] imm;
        logic        use_rs1;
        logic        use_rs2;
        // Unknown opcode, register fields and imm are zero
        logic        illegal;
    } inst_entry_t;

    // Two entries, index 0 is the older one
    typedef inst_entry_t [1:0] inst_pair_t;

endpackage : frontend_pkg

`default_nettype wire

// ==== hdl/pair_push_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pair_push_if
    import frontend_pkg::*;
();

    // Pair buffer to queue
    logic       push;
    inst_pair_t pair;

    // Queue to pair buffer, one pulse per freed pair slot
    logic       credit_return;

    modport src (output push, output pair, input credit_return);

    modport dst (input push, input pair, output credit_return);

endinterface : pair_push_if

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module fetch_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        accept,
    input  logic        imem_resp,
    output logic [31:0] imem_addr,
    output logic [3:0]  imem_rmask,
    output logic [31:0] fetch_pc,
    output logic        fetch_valid
);

    logic [31:0] pc;
    // Low only during the reset cycles
    logic        active;
    // A request is in flight and waits for imem_resp
    logic        outstanding;
    logic        request;

    // Once started, a request stays up until its response
    // New requests only start while the pair buffer has room
    assign request = active && (outstanding || accept);

    assign imem_rmask = request ? 4'hf : 4'h0;
    assign imem_addr = pc;
    assign fetch_pc = pc;

    // Response for the word at pc, decode sees it this cycle
    assign fetch_valid = request && imem_resp;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FE_RESET_PC;
            active <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            active <= 1'b1;
            // Strictly sequential stream
            if (fetch_valid) begin
                pc <= pc + 32'd4;
            end
            if (imem_resp) begin
                outstanding <= 1'b0;
            end else if (request) begin
                outstanding <= 1'b1;
            end
        end
    end

    // Instruction words only
    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        request |-> (imem_addr[1:0] == 2'b00));

    // Address and read mask hold until the memory answers
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (request && !imem_resp) |=> (request && $stable(imem_addr)));

endmodule : fetch_stage

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import frontend_pkg::*;
(
    input  logic [31:0] fetch_pc,
    input  logic [31:0] imem_rdata,
    output inst_entry_t entry
);

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    logic [6:0]  opcode;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = imem_rdata[6:0];

    // Immediates for every format, sign bit is always inst[31]
    assign imm_i = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
    assign imm_s = {{20{imem_rdata[31]}}, imem_rdata[31:25], imem_rdata[11:7]};
    assign imm_b = {{19{imem_rdata[31]}}, imem_rdata[31], imem_rdata[7],
                    imem_rdata[30:25], imem_rdata[11:8], 1'b0};
    assign imm_u = {imem_rdata[31:12], 12'h000};
    assign imm_j = {{11{imem_rdata[31]}}, imem_rdata[31], imem_rdata[19:12],
                    imem_rdata[20], imem_rdata[30:21], 1'b0};

    always_comb begin
        // Fields not used by a format stay zero
        entry = '0;
        entry.pc = fetch_pc;
        entry.inst = imem_rdata;
        case (opcode)
            // R format
            OPC_OP: begin
                entry.op = OP_ALU;
                entry.rd = imem_rdata[11:7];
                entry.rs1 = imem_rdata[19:15];
                entry.rs2 = imem_rdata[24:20];
                entry.use_rs1 = 1'b1;
                entry.use_rs2 = 1'b1;
            end
            // I format, jalr counts as a jump
            OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_MISC_MEM, OPC_SYSTEM: begin
                entry.op = (opcode == OPC_OP_IMM) ? OP_ALU_IMM :
                           (opcode == OPC_LOAD)   ? OP_LOAD :
                           (opcode == OPC_JALR)   ? OP_JUMP : OP_SYSTEM;
                entry.rd = imem_rdata[11:7];
                entry.rs1 = imem_rdata[19:15];
                entry.imm = imm_i;
                entry.use_rs1 = 1'b1;
            end
            // S format
            OPC_STORE: begin
                entry.op = OP_STORE;
                entry.rs1 = imem_rdata[19:15];
                entry.rs2 = imem_rdata[24:20];
                entry.imm = imm_s;
                entry.use_rs1 = 1'b1;
                entry.use_rs2 = 1'b1;
            end
            // B format
            OPC_BRANCH: begin
                entry.op = OP_BRANCH;
                entry.rs1 = imem_rdata[19:15];
                entry.rs2 = imem_rdata[24:20];
                entry.imm = imm_b;
                entry.use_rs1 = 1'b1;
                entry.use_rs2 = 1'b1;
            end
            // U format
            OPC_LUI, OPC_AUIPC: begin
                entry.op = OP_UPPER;
                entry.rd = imem_rdata[11:7];
                entry.imm = imm_u;
            end
            // J format
            OPC_JAL: begin
                entry.op = OP_JUMP;
                entry.rd = imem_rdata[11:7];
                entry.imm = imm_j;
            end
            // Unknown opcode, handled by the backend as a trap
            default: begin
                entry.op = OP_SYSTEM;
                entry.illegal = 1'b1;
            end
        endcase
    end

endmodule : decode_stage

`default_nettype wire

// ==== hdl/pair_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module pair_buffer
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_valid,
    input  inst_entry_t entry,
    output logic        accept,
    pair_push_if.src    q
);

    inst_entry_t                  slot0;
    inst_entry_t                  slot1;
    // Number of filled slots, 0 to 2
    logic [1:0]                   fill;
    logic [1:0]                   fill_next;
    // Free pair slots in the queue
    logic [`FE_PAIR_CREDIT_W-1:0] credits;
    logic [`FE_PAIR_CREDIT_W-1:0] credits_next;
    logic                         push_q;

    // Full pair waiting on a credit blocks fetch
    assign accept = !((fill == 2'd2) && !push_q);

    assign q.push = push_q;
    assign q.pair[0] = slot0;
    assign q.pair[1] = slot1;

    always_comb begin
        // A push empties both slots, a capture refills slot 0 in the same cycle
        case ({push_q, fetch_valid})
            2'b10: fill_next = 2'd0;
            2'b11: fill_next = 2'd1;
            2'b01: fill_next = fill + 2'd1;
            default: fill_next = fill;
        endcase
        credits_next = credits;
        if (push_q && !q.credit_return) begin
            credits_next = credits - `FE_PAIR_CREDIT_W'(1);
        end else if (!push_q && q.credit_return) begin
            credits_next = credits + `FE_PAIR_CREDIT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= 2'd0;
            credits <= `FE_PAIR_CREDIT_W'(`FE_QUEUE_PAIRS);
            push_q <= 1'b0;
        end else begin
            fill <= fill_next;
            credits <= credits_next;
            // Push the cycle after the pair completes, or once a credit comes back
            push_q <= (fill_next == 2'd2) && (credits_next != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            if (push_q || (fill == 2'd0)) begin
                slot0 <= entry;
            end else begin
                slot1 <= entry;
            end
        end
    end

    // Queue must have a free pair slot
    push_has_credit: assert property (@(posedge clk) disable iff (rst)
        q.push |-> (credits != '0));

    // More returns than pushes means the queue and buffer disagree
    credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= `FE_QUEUE_PAIRS);

    // Fetch only delivers a word when a slot is free
    no_lost_word: assert property (@(posedge clk) disable iff (rst)
        fetch_valid |-> accept);

endmodule : pair_buffer

`default_nettype wire

// ==== hdl/inst_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module inst_queue
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    pair_push_if.dst    q,
    input  logic        issue_credit,
    output logic        issue_valid,
    output inst_entry_t issue_entry
);

    inst_pair_t                    mem [`FE_QUEUE_PAIRS];
    logic [`FE_QUEUE_PTR_W-1:0]    head;
    logic [`FE_QUEUE_PTR_W-1:0]    tail;
    // Which entry of the head pair issues next
    logic                          half;
    // Occupied pair slots
    logic [`FE_PAIR_CREDIT_W-1:0]  used;
    // Credits granted by the backend and not yet spent
    logic [`FE_ISSUE_CREDIT_W-1:0] credits;
    logic                          full;
    logic                          empty;
    logic                          fire;
    logic                          pop;
    logic                          ret_q;

    // Wraps for any depth, not only powers of two
    function automatic logic [`FE_QUEUE_PTR_W-1:0] next_ptr(
        input logic [`FE_QUEUE_PTR_W-1:0] ptr
    );
        if (ptr == `FE_QUEUE_PTR_W'(`FE_QUEUE_PAIRS - 1)) begin
            return '0;
        end
        return ptr + `FE_QUEUE_PTR_W'(1);
    endfunction

    assign full = (used == `FE_PAIR_CREDIT_W'(`FE_QUEUE_PAIRS));
    assign empty = (used == '0);

    // Issue one entry when something is at the head and a credit is held
    assign fire = !empty && (credits != '0);
    // Second entry of the pair leaves, slot frees
    assign pop = fire && half;

    assign q.credit_return = ret_q;

    always_ff @(posedge clk) begin
        if (q.push) begin
            mem[tail] <= q.pair;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue_entry <= mem[head][half];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            half <= 1'b0;
            used <= '0;
            credits <= '0;
            issue_valid <= 1'b0;
            ret_q <= 1'b0;
        end else begin
            if (q.push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            if (fire) begin
                half <= !half;
            end
            case ({q.push, pop})
                2'b10: used <= used + `FE_PAIR_CREDIT_W'(1);
                2'b01: used <= used - `FE_PAIR_CREDIT_W'(1);
                default: used <= used;
            endcase
            // Backend grant and issue may land in the same cycle
            case ({issue_credit, fire})
                2'b10: credits <= credits + `FE_ISSUE_CREDIT_W'(1);
                2'b01: credits <= credits - `FE_ISSUE_CREDIT_W'(1);
                default: credits <= credits;
            endcase
            issue_valid <= fire;
            // Pulses alongside the second entry of the pair
            ret_q <= pop;
        end
    end

    // Pair buffer credits keep pushes away from a full queue
    no_push_full: assert property (@(posedge clk) disable iff (rst)
        q.push |-> !full);

    // Backend never grants more than the front end can hold
    issue_credits_bounded: assert property (@(posedge clk) disable iff (rst)
        credits <= `FE_ISSUE_CREDIT_MAX);

endmodule : inst_queue

`default_nettype wire

// ==== hdl/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Instruction memory
    output logic [31:0] imem_addr,
    output logic [3:0]  imem_rmask,
    input  logic [31:0] imem_rdata,
    input  logic        imem_resp,

    // Backend issue
    input  logic        issue_credit,
    output logic        issue_valid,
    output logic [31:0] issue_pc,
    output logic [31:0] issue_inst,
    output op_class_e   issue_op,
    output logic [4:0]  issue_rd,
    output logic [4:0]  issue_rs1,
    output logic [4:0]  issue_rs2,
    output logic [31:0] issue_imm,
    output logic        issue_illegal
);

    logic        accept;
    logic [31:0] fetch_pc;
    logic        fetch_valid;
    inst_entry_t decoded;
    inst_entry_t issue_entry;

    // Pair buffer to queue, pairs one way and credits back
    pair_push_if pair_push ();

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .imem_resp   (imem_resp),
        .imem_addr   (imem_addr),
        .imem_rmask  (imem_rmask),
        .fetch_pc    (fetch_pc),
        .fetch_valid (fetch_valid)
    );

    decode_stage decode_stage_inst (
        .fetch_pc   (fetch_pc),
        .imem_rdata (imem_rdata),
        .entry      (decoded)
    );

    pair_buffer pair_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .entry       (decoded),
        .accept      (accept),
        .q           (pair_push.src)
    );

    inst_queue inst_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .q            (pair_push.dst),
        .issue_credit (issue_credit),
        .issue_valid  (issue_valid),
        .issue_entry  (issue_entry)
    );

    // Issued entry out as plain ports
    assign issue_pc = issue_entry.pc;
    assign issue_inst = issue_entry.inst;
    assign issue_op = issue_entry.op;
    assign issue_rd = issue_entry.rd;
    assign issue_rs1 = issue_entry.rs1;
    assign issue_rs2 = issue_entry.rs2;
    assign issue_imm = issue_entry.imm;
    assign issue_illegal = issue_entry.illegal;

endmodule : frontend_top

`default_nettype wire

// ==== verif/frontend_tb_tasks.svh ====
`ifndef FRONTEND_TB_TASKS_SVH
`define FRONTEND_TB_TASKS_SVH

// Expected decode of one word, straight from the RV32I formats
function automatic inst_entry_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
    inst_entry_t e;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    imm_i = $signed(w) >>> 20;
    imm_s = {imm_i[31:5], w[11:7]};
    imm_b = {imm_i[31:12], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {imm_i[31:20], w[19:12], w[20], w[30:21], 1'b0};
    e = '0;
    e.pc = pc;
    e.inst = w;
    case (w[6:0])
        7'h33: begin
            e.op = OP_ALU;
            e.rd = w[11:7];
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
            e.use_rs1 = 1'b1;
            e.use_rs2 = 1'b1;
        end
        7'h13, 7'h03, 7'h67, 7'h0f, 7'h73: begin
            case (w[6:0])
                7'h13: e.op = OP_ALU_IMM;
                7'h03: e.op = OP_LOAD;
                7'h67: e.op = OP_JUMP;
                default: e.op = OP_SYSTEM;
            endcase
            e.rd = w[11:7];
            e.rs1 = w[19:15];
            e.imm = imm_i;
            e.use_rs1 = 1'b1;
        end
        7'h23, 7'h63: begin
            e.op = (w[6:0] == 7'h23) ? OP_STORE : OP_BRANCH;
            e.rs1 = w[19:15];
            e.rs2 = w[24:20];
            e.imm = (w[6:0] == 7'h23) ? imm_s : imm_b;
            e.use_rs1 = 1'b1;
            e.use_rs2 = 1'b1;
        end
        7'h37, 7'h17: begin
            e.op = OP_UPPER;
            e.rd = w[11:7];
            e.imm = {w[31:12], 12'h000};
        end
        7'h6f: begin
            e.op = OP_JUMP;
            e.rd = w[11:7];
            e.imm = imm_j;
        end
        // Unknown opcode
        default: begin
            e.op = OP_SYSTEM;
            e.illegal = 1'b1;
        end
    endcase
    return e;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
endtask

task automatic check_mask(input string name, input logic [3:0] got, input logic [3:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%01h, expected 0x%01h", name, got, exp);
    end
endtask

task automatic check_logic(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED %s: got 0x%01h, expected 0x%01h", name, got, exp);
    end
endtask

// The use flags do not leave the top level
task automatic check_entry(input inst_entry_t got, input inst_entry_t exp);
    check_word("issue_pc", got.pc, exp.pc);
    check_word("issue_inst", got.inst, exp.inst);
    check_word("issue_op", 32'(got.op), 32'(exp.op));
    check_word("issue_rd", 32'(got.rd), 32'(exp.rd));
    check_word("issue_rs1", 32'(got.rs1), 32'(exp.rs1));
    check_word("issue_rs2", 32'(got.rs2), 32'(exp.rs2));
    check_word("issue_imm", got.imm, exp.imm);
    check_logic("issue_illegal", got.illegal, exp.illegal);
endtask

// Eight cycles of reset, outputs idle throughout
task automatic apply_reset();
    @(negedge clk);
    rst <= 1'b1;
    issue_credit <= 1'b0;
    repeat (8) begin
        @(negedge clk);
        check_logic("issue_valid", issue_valid, 1'b0);
        check_mask("imem_rmask", imem_rmask, 4'h0);
    end
    issued = 0;
    granted = 0;
    issue_log.delete();
    rst <= 1'b0;
endtask

// Back to back credit pulses
task automatic grant_credits(input int n);
    repeat (n) begin
        @(negedge clk);
        issue_credit <= 1'b1;
    end
    @(negedge clk);
    issue_credit <= 1'b0;
endtask

task automatic wait_issued(input int target);
    @(posedge clk);
    while (issued < target) begin
        @(posedge clk);
    end
endtask

// Grants in chunks of 8 so the held count stays below the credit limit
task automatic run_stream(input int from, input int to);
    int target;
    int n;
    target = from;
    while (target < to) begin
        n = (to - target > 8) ? 8 : to - target;
        grant_credits(n);
        target += n;
        wait_issued(target);
    end
endtask

task automatic check_reset_state();
    rand_delay = 1'b0;
    apply_reset();
    // First request the cycle after reset
    @(negedge clk);
    check_mask("imem_rmask", imem_rmask, 4'hf);
    check_word("imem_addr", imem_addr, `FE_RESET_PC);
    repeat (20) begin
        check_logic("issue_valid", issue_valid, 1'b0);
        @(negedge clk);
    end
endtask

task automatic run_in_order();
    logic [31:0] pc;
    rand_delay = 1'b0;
    apply_reset();
    run_stream(0, PROG_LEN);
    // Program order, decoded word by word
    ref_stream.delete();
    for (int i = 0; i < PROG_LEN; i++) begin
        pc = `FE_RESET_PC + 32'(i) * 32'd4;
        ref_stream.push_back(ref_decode(mem_word(pc), pc));
    end
endtask

task automatic limit_credits();
    apply_reset();
    run_stream(0, 5);
    repeat (30) @(posedge clk);
    check_count++;
    if (issued != 5) begin
        error_count++;
        $display("%0d entries issued on 5 credits", issued);
    end
    run_stream(5, PROG_LEN);
endtask

task automatic apply_back_pressure();
    apply_reset();
    repeat (60) @(negedge clk);
    // Queue full plus one pair waiting in the pair buffer
    check_mask("imem_rmask", imem_rmask, 4'h0);
    check_word("imem_addr", imem_addr, `FE_RESET_PC + 8 * (`FE_QUEUE_PAIRS + 1));
    // Still parked ten cycles later
    repeat (10) @(negedge clk);
    check_mask("imem_rmask", imem_rmask, 4'h0);
    check_word("imem_addr", imem_addr, `FE_RESET_PC + 8 * (`FE_QUEUE_PAIRS + 1));
    run_stream(0, PROG_LEN);
endtask

task automatic vary_latency();
    rand_delay = 1'b1;
    apply_reset();
    run_stream(0, PROG_LEN);
    check_count++;
    if (issue_log.size() != ref_stream.size()) begin
        error_count++;
        $display("Random latency run issued %0d entries instead of %0d",
                 issue_log.size(), ref_stream.size());
    end else begin
        foreach (ref_stream[i]) begin
            check_entry(issue_log[i], ref_stream[i]);
        end
    end
    rand_delay = 1'b0;
endtask

`endif

// ==== verif/frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module frontend_tb
    import frontend_pkg::*;
();

    localparam int PROG_LEN = 14;
    // Each run resets, fetches the program once and idles a little
    localparam int RUNS = 5;
    localparam int TIMEOUT_CYCLES = RUNS * (PROG_LEN * 8 + 200);

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imem_addr;
    logic [3:0]  imem_rmask;
    logic [31:0] imem_rdata;
    logic        imem_resp;
    logic        issue_credit;
    logic        issue_valid;
    logic [31:0] issue_pc;
    logic [31:0] issue_inst;
    op_class_e   issue_op;
    logic [4:0]  issue_rd;
    logic [4:0]  issue_rs1;
    logic [4:0]  issue_rs2;
    logic [31:0] issue_imm;
    logic        issue_illegal;

    // Program words from FE_RESET_PC upwards
    logic [31:0] prog [PROG_LEN];

    // Memory model state
    logic        mem_busy;
    int          mem_wait;
    logic [31:0] mem_req_addr;
    logic        rand_delay;
    logic [31:0] rng_state;

    // Backend model, counts since the last reset
    int          granted;
    int          issued;
    inst_entry_t issue_log [$];
    // Expected issue order, reference for the random latency run
    inst_entry_t ref_stream [$];

    int          error_count;
    int          check_count;
    int          cycle_count;

    frontend_top frontend_top_inst (
        .clk           (clk),
        .rst           (rst),
        .imem_addr     (imem_addr),
        .imem_rmask    (imem_rmask),
        .imem_rdata    (imem_rdata),
        .imem_resp     (imem_resp),
        .issue_credit  (issue_credit),
        .issue_valid   (issue_valid),
        .issue_pc      (issue_pc),
        .issue_inst    (issue_inst),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_illegal (issue_illegal)
    );

    always #2 clk = ~clk;

    // Word stored at a fetch address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `FE_RESET_PC) >> 2;
        if (idx < PROG_LEN) begin
            return prog[idx];
        end
        // Past the program every word is unique to its address
        return addr ^ 32'hc0de_0013;
    endfunction

    `include "frontend_tb_tasks.svh"

    // Memory model, one request at a time, 1 to 4 cycles to answer
    always @(negedge clk) begin
        if (rst) begin
            mem_busy = 1'b0;
            imem_resp <= 1'b0;
        end else begin
            imem_resp <= 1'b0;
            if (mem_busy && (imem_rmask != 4'hf || imem_addr != mem_req_addr)) begin
                error_count++;
                $display("Fetch request changed before its response at 0x%08h", mem_req_addr);
            end
            if (imem_rmask == 4'hf && !mem_busy) begin
                mem_busy = 1'b1;
                mem_req_addr = imem_addr;
                mem_wait = 1;
                if (rand_delay) begin
                    rng_state = xorshift32(rng_state);
                    mem_wait = int'(rng_state[1:0]) + 1;
                end
            end
            if (mem_busy) begin
                mem_wait = mem_wait - 1;
                if (mem_wait == 0) begin
                    imem_resp <= 1'b1;
                    imem_rdata <= mem_word(mem_req_addr);
                    mem_busy = 1'b0;
                end
            end
        end
    end

    // Credits the DUT has been granted
    always @(posedge clk) begin
        if (!rst && issue_credit) begin
            granted <= granted + 1;
        end
    end

    // Every issued entry must be the next PC in order, decoded correctly
    always @(negedge clk) begin : issue_monitor
        inst_entry_t got;
        inst_entry_t exp;
        logic [31:0] exp_pc;
        if (issue_valid) begin
            if (issued >= granted) begin
                error_count++;
                $display("Entry %0d issued without a backend credit", issued);
            end
            exp_pc = `FE_RESET_PC + 32'(issued) * 32'd4;
            exp = ref_decode(mem_word(exp_pc), exp_pc);
            got = '0;
            got.pc = issue_pc;
            got.inst = issue_inst;
            got.op = issue_op;
            got.rd = issue_rd;
            got.rs1 = issue_rs1;
            got.rs2 = issue_rs2;
            got.imm = issue_imm;
            got.illegal = issue_illegal;
            check_entry(got, exp);
            issue_log.push_back(got);
            issued++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the issue stream stalled", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        imem_rdata = '0;
        imem_resp = 1'b0;
        issue_credit = 1'b0;
        mem_busy = 1'b0;
        mem_wait = 0;
        mem_req_addr = '0;
        rand_delay = 1'b0;
        rng_state = 32'h50fe_6774;
        granted = 0;
        issued = 0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;

        // One word of every format, then an unknown opcode
        prog[0] = 32'h002081b3;
        prog[1] = 32'h407302b3;
        prog[2] = 32'hfff00093;
        prog[3] = 32'h0ff4f493;
        prog[4] = 32'h00812203;
        prog[5] = 32'hfe512e23;
        prog[6] = 32'hfe208ce3;
        prog[7] = 32'h123453b7;
        prog[8] = 32'hfffff417;
        prog[9] = 32'h008000ef;
        prog[10] = 32'h00008067;
        prog[11] = 32'h00000073;
        prog[12] = 32'h0ff0000f;
        prog[13] = 32'h00000000;

        check_reset_state();
        run_in_order();
        limit_credits();
        apply_back_pressure();
        vary_latency();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : frontend_tb

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
+incdir+verif
hdl/frontend_pkg.sv
hdl/pair_push_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/pair_buffer.sv
hdl/inst_queue.sv
hdl/frontend_top.sv
verif/frontend_tb.sv
